// File: list.f
+incdir+test
rtl/apb_iob_pkg.sv
rtl/apb_iob_bridge.sv
rtl/iob_reg_bank.sv
rtl/apb_iob_top.sv
test/apb_iob_tb.sv

// File: rtl/apb_iob_bridge.sv
// APB subordinate to IOb manager. Handles one access at a time, no PSLVERR
// Ready from the IOb side is ignored in the first access cycle
module apb_iob_bridge (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::apb_req_t apb_req_i,
   output apb_iob_pkg::apb_rsp_t apb_rsp_o,
   output apb_iob_pkg::iob_req_t iob_req_o,
   input  apb_iob_pkg::iob_rsp_t iob_rsp_i
);

   apb_iob_pkg::bridge_state_e     state_q;
   apb_iob_pkg::bridge_state_e     state_d;
   logic                           iob_valid;
   logic                           iob_rready;
   logic                           apb_ready_d;
   logic                           apb_ready_q;
   logic [apb_iob_pkg::DATA_W-1:0] apb_rdata_q;

   //**************************************************************************
   // Bus outputs
   //**************************************************************************

   always_comb begin
      iob_req_o.valid  = iob_valid;
      iob_req_o.addr   = apb_req_i.addr;
      iob_req_o.wdata  = apb_req_i.wdata;
      // Reads go out with no strobes so the subordinate can tell them apart
      iob_req_o.wstrb  = apb_req_i.write ? apb_req_i.wstrb : '0;
      iob_req_o.rready = iob_rready;
   end

   always_comb begin
      apb_rsp_o.ready = apb_ready_q;
      apb_rsp_o.rdata = apb_rdata_q;
   end

   //**************************************************************************
   // Sequencer
   //**************************************************************************

   always_comb begin
      state_d     = state_q;
      iob_valid   = 1'b0;
      iob_rready  = 1'b0;
      apb_ready_d = 1'b0;

      case (state_q)
         apb_iob_pkg::WAIT_ENABLE: begin
            if (apb_req_i.sel && apb_req_i.enable) begin
               iob_valid = 1'b1;
               state_d   = apb_iob_pkg::WAIT_READY;
            end
         end
         apb_iob_pkg::WAIT_READY: begin
            iob_valid = 1'b1;
            if (iob_rsp_i.ready) begin
               if (apb_req_i.write) begin
                  // A write is done once the subordinate accepts it
                  apb_ready_d = 1'b1;
                  state_d     = apb_iob_pkg::WAIT_APB_READY;
               end else begin
                  state_d = apb_iob_pkg::RVALID;
               end
            end
         end
         apb_iob_pkg::RVALID: begin
            iob_rready = 1'b1;
            if (iob_rsp_i.rvalid) begin
               apb_ready_d = 1'b1;
               state_d     = apb_iob_pkg::WAIT_APB_READY;
            end
         end
         default: begin
            // One idle cycle lets the master drop enable before we look again
            state_d = apb_iob_pkg::WAIT_ENABLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= apb_iob_pkg::WAIT_ENABLE;
         apb_ready_q <= 1'b0;
         apb_rdata_q <= '0;
      end else begin
         state_q     <= state_d;
         apb_ready_q <= apb_ready_d;
         if (iob_rready && iob_rsp_i.rvalid) begin
            apb_rdata_q <= iob_rsp_i.rdata;
         end
      end
   end

   //**************************************************************************
   // Assertions
   //**************************************************************************

   a_valid_held: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (state_q == apb_iob_pkg::WAIT_READY && !iob_rsp_i.ready) |=> iob_req_o.valid
   ) else $error("IOb valid dropped before the request was accepted");

   a_pready_pulse: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      apb_rsp_o.ready |=> !apb_rsp_o.ready
   ) else $error("PREADY high for more than one cycle");

endmodule

// File: rtl/apb_iob_pkg.sv
// Shared widths, bus structs and bridge states for the APB to IOb bridge
// Byte addressed buses with one 32-bit word per register, no error signalling
package apb_iob_pkg;

   localparam int DATA_W    = 32;
   localparam int WSTRB_W   = DATA_W / 8;
   localparam int ADDR_W    = 8;
   localparam int NUM_REGS  = 16;
   localparam int REG_IDX_W = $clog2(NUM_REGS);

   // Bridge sequence, one APB access at a time
   typedef enum logic [1:0] {
      WAIT_ENABLE    = 2'd0,
      WAIT_READY     = 2'd1,
      RVALID         = 2'd2,
      WAIT_APB_READY = 2'd3
   } bridge_state_e;

   //**************************************************************************
   // Bus structs
   //**************************************************************************

   typedef struct packed {
      logic               sel;
      logic               enable;
      logic               write;
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  wdata;
      logic [WSTRB_W-1:0] wstrb;
   } apb_req_t;

   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
   } apb_rsp_t;

   // An all zero wstrb marks a read
   typedef struct packed {
      logic               valid;
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  wdata;
      logic [WSTRB_W-1:0] wstrb;
      logic               rready;
   } iob_req_t;

   typedef struct packed {
      logic              ready;
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
   } iob_rsp_t;

endpackage

// File: rtl/apb_iob_top.sv
// APB bridge in front of the IOb register bank
// The APB side sees a fixed latency of 2 cycles for writes and 3 for reads
module apb_iob_top (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::apb_req_t apb_req_i,
   output apb_iob_pkg::apb_rsp_t apb_rsp_o
);

   //**************************************************************************
   // Internal IOb bus
   //**************************************************************************

   apb_iob_pkg::iob_req_t iob_req;
   apb_iob_pkg::iob_rsp_t iob_rsp;

   //**************************************************************************
   // Bridge and bank
   //**************************************************************************

   apb_iob_bridge u_bridge (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .apb_req_i (apb_req_i),
      .apb_rsp_o (apb_rsp_o),
      .iob_req_o (iob_req),
      .iob_rsp_i (iob_rsp)
   );

   // The bank answers with one wait state and holds read data until rready
   iob_reg_bank u_bank (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .iob_req_i (iob_req),
      .iob_rsp_o (iob_rsp)
   );

endmodule

// File: rtl/iob_reg_bank.sv
// IOb register bank with sixteen byte-writable words at byte address 0x00 to 0x3f
// Accesses above that are dropped on write and read back as zero
module iob_reg_bank (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::iob_req_t iob_req_i,
   output apb_iob_pkg::iob_rsp_t iob_rsp_o
);

   logic [apb_iob_pkg::DATA_W-1:0]    regs_q [apb_iob_pkg::NUM_REGS];
   logic [apb_iob_pkg::DATA_W-1:0]    rdata_q;
   logic                              ready_q;
   logic                              rvalid_q;
   logic                              accept;
   logic                              is_write;
   logic                              in_range;
   logic [apb_iob_pkg::REG_IDX_W-1:0] idx;

   // Word index sits right above the byte offset, the upper bits must be zero
   assign idx      = iob_req_i.addr[apb_iob_pkg::REG_IDX_W+1:2];
   assign in_range = (iob_req_i.addr[apb_iob_pkg::ADDR_W-1:apb_iob_pkg::REG_IDX_W+2] == '0);
   assign accept   = iob_req_i.valid && ready_q;
   assign is_write = |iob_req_i.wstrb;

   assign iob_rsp_o = '{ready: ready_q, rvalid: rvalid_q, rdata: rdata_q};

   //**************************************************************************
   // Handshake
   //**************************************************************************

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ready_q  <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         // Single wait state, and no new request while a read answer is held
         ready_q <= iob_req_i.valid && !ready_q && !rvalid_q;
         if (accept && !is_write) begin
            rvalid_q <= 1'b1;
         end else if (iob_req_i.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   //**************************************************************************
   // Storage
   //**************************************************************************

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < apb_iob_pkg::NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (accept && in_range) begin
         for (int b = 0; b < apb_iob_pkg::WSTRB_W; b++) begin
            if (iob_req_i.wstrb[b]) begin
               regs_q[idx][8*b +: 8] <= iob_req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept && !is_write) begin
         rdata_q <= in_range ? regs_q[idx] : '0;
      end
   end

   //**************************************************************************
   // Assertions
   //**************************************************************************

   a_no_ready_while_rvalid: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      rvalid_q |-> !ready_q
   ) else $error("Bank ready raised while a read response is pending");

   a_rdata_held: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (rvalid_q && !iob_req_i.rready) |=> $stable(rdata_q)
   ) else $error("Read data changed under back-pressure");

endmodule

// File: test/apb_iob_tb_tasks.svh
// APB master tasks and the value checker, included in the testbench module body
// Inputs change on rising edges, outputs are sampled on falling edges

//****************************************************************************
// Checker
//****************************************************************************

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
   checks++;
   if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
   end
endtask

//****************************************************************************
// APB master
//****************************************************************************

// Setup cycle, then access held until PREADY, latency counted from the access cycle
task automatic apb_access(input string name, input logic write,
                          input logic [7:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, output logic [31:0] rdata,
                          output int latency);
   apb_iob_pkg::apb_req_t req;
   req.sel    = 1'b1;
   req.enable = 1'b0;
   req.write  = write;
   req.addr   = addr;
   req.wdata  = wdata;
   req.wstrb  = wstrb;
   @(posedge clk);
   apb_req <= req;
   // PREADY of the previous access must already be gone
   @(negedge clk);
   check_value({name, "_pready_in_setup"}, 1'b0, apb_rsp.ready);
   @(posedge clk);
   apb_req.enable <= 1'b1;
   latency = 0;
   @(negedge clk);
   while (!apb_rsp.ready) begin
      @(negedge clk);
      latency++;
   end
   rdata = apb_rsp.rdata;
endtask

task automatic release_bus();
   @(posedge clk);
   apb_req <= '0;
   @(negedge clk);
   check_value("pready_after_last", 1'b0, apb_rsp.ready);
endtask

// File: test/apb_iob_tb.sv
// Testbench for the APB to IOb bridge with its register bank
// Expected read data comes from a shadow copy of the registers built with the table
// Latency is fixed by the bank, 2 cycles for writes and 3 for reads after access
module apb_iob_tb;

   logic                  clk;
   logic                  rst_n;
   apb_iob_pkg::apb_req_t apb_req;
   apb_iob_pkg::apb_rsp_t apb_rsp;

   int checks      = 0;
   int errors      = 0;
   int cycle_cnt   = 0;
   int cycle_limit = 0;

   // Stimulus table, one entry per APB access
   string                                name_q[$];
   logic                                 write_q[$];
   logic [apb_iob_pkg::ADDR_W-1:0]       addr_q[$];
   logic [apb_iob_pkg::DATA_W-1:0]       wdata_q[$];
   logic [apb_iob_pkg::WSTRB_W-1:0]      wstrb_q[$];
   logic [apb_iob_pkg::DATA_W-1:0]       exp_q[$];

   // Shadow of the bank, updated while the table is built
   logic [apb_iob_pkg::DATA_W-1:0]       shadow [apb_iob_pkg::NUM_REGS];

   `include "apb_iob_tb_tasks.svh"

   apb_iob_top DUT (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   //**************************************************************************
   // Table construction
   //**************************************************************************

   task automatic add_write(input string name, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb);
      int idx;
      idx = addr >> 2;
      name_q.push_back(name);
      write_q.push_back(1'b1);
      addr_q.push_back(addr);
      wdata_q.push_back(wdata);
      wstrb_q.push_back(wstrb);
      exp_q.push_back('0);
      // Words above the bank are dropped
      if (addr < apb_iob_pkg::NUM_REGS * 4) begin
         for (int b = 0; b < apb_iob_pkg::WSTRB_W; b++) begin
            if (wstrb[b]) begin
               shadow[idx][8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end
   endtask

   task automatic add_read(input string name, input logic [7:0] addr);
      name_q.push_back(name);
      write_q.push_back(1'b0);
      addr_q.push_back(addr);
      wdata_q.push_back('0);
      wstrb_q.push_back('0);
      exp_q.push_back((addr < apb_iob_pkg::NUM_REGS * 4) ? shadow[addr >> 2] : '0);
   endtask

   //**************************************************************************
   // Main sequence
   //**************************************************************************

   initial begin
      logic [31:0] rdata;
      int          lat;

      clk     = 1'b0;
      rst_n   = 1'b0;
      apb_req = '0;
      void'($urandom(56015));
      for (int i = 0; i < apb_iob_pkg::NUM_REGS; i++) begin
         shadow[i] = '0;
      end

      for (int i = 0; i < apb_iob_pkg::NUM_REGS; i++) begin
         add_read($sformatf("reset_read_r%0d", i), 8'(i * 4));
      end
      add_write("full_write_r5", 8'h14, $urandom(), 4'hf);
      add_read("full_read_r5", 8'h14);
      add_write("full_write_r10", 8'h28, $urandom(), 4'hf);
      add_read("full_read_r10", 8'h28);
      add_write("known_write_r2", 8'h08, 32'h1122_3344, 4'hf);
      add_write("strobe_0101_r2", 8'h08, 32'haabb_ccdd, 4'b0101);
      add_read("strobe_read_r2", 8'h08);
      add_write("strobe_1000_r10", 8'h28, $urandom(), 4'b1000);
      add_read("strobe_read_r10", 8'h28);
      add_write("range_write_40", 8'h40, $urandom(), 4'hf);
      add_write("range_write_fc", 8'hfc, $urandom(), 4'hf);
      // These alias r2 and r5 in the low address bits, which hold data
      add_read("range_read_48", 8'h48);
      add_read("range_read_94", 8'h94);
      for (int i = 0; i < apb_iob_pkg::NUM_REGS; i++) begin
         add_read($sformatf("final_read_r%0d", i), 8'(i * 4));
      end
      // Each access takes at most 5 cycles, so 8 per entry leaves margin
      cycle_limit = name_q.size() * 8 + 20;

      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) begin
         @(negedge clk);
         check_value("pready_after_reset", 1'b0, apb_rsp.ready);
         check_value("prdata_after_reset", '0, apb_rsp.rdata);
      end

      // Accesses follow each other with no idle cycle between them
      for (int i = 0; i < name_q.size(); i++) begin
         apb_access(name_q[i], write_q[i], addr_q[i], wdata_q[i], wstrb_q[i], rdata, lat);
         check_value({name_q[i], "_latency"}, write_q[i] ? 2 : 3, lat);
         if (!write_q[i]) begin
            check_value(name_q[i], exp_q[i], rdata);
         end
      end
      release_bus();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
